/* src/gpu_isa_pkg.sv */
// ISA package with opcodes, scheduler states, field widths and the decoded instruction
`default_nettype none

package gpu_isa_pkg;

    localparam int num_lanes = 4;
    localparam int lane_idx_w = 2;
    localparam int num_regs = 16;
    localparam int reg_addr_w = 4;
    localparam int data_w = 8;
    localparam int pc_w = 8;
    localparam int instr_w = 16;
    localparam int tc_w = 3;

    // Read-only registers holding the thread count and the lane index
    localparam int reg_tcount = 14;
    localparam int reg_lane = 15;

    // Opcode in instruction bits 15..12, codes above RET decode as NOP
    typedef enum logic [3:0] {
        NOP   = 4'h0,
        ADD   = 4'h1,
        SUB   = 4'h2,
        MUL   = 4'h3,
        AND   = 4'h4,
        CONST = 4'h5,
        LDR   = 4'h6,
        STR   = 4'h7,
        RET   = 4'h8
    } opcode_e;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        DONE
    } sched_state_e;

    // imm overlaps rs and rt in the instruction word
    typedef struct packed {
        opcode_e               op;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [data_w-1:0]     imm;
    } decoded_instr_t;

endpackage

`default_nettype wire

/* src/gpu_bus_pkg.sv */
// Bus package with Wishbone classic structs and the per-lane memory request
`default_nettype none

package gpu_bus_pkg;

    localparam int adr_w = 8;
    localparam int dat_w = 8;

    // Master to slave, stb always travels with cyc
    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [adr_w-1:0] adr;
        logic [dat_w-1:0] dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic             ack;
        logic [dat_w-1:0] dat;
    } wb_rsp_t;

    // Address from rs and store data from rt of one lane
    typedef struct packed {
        logic [adr_w-1:0] addr;
        logic [dat_w-1:0] wdata;
    } lane_mem_req_t;

endpackage

`default_nettype wire

/* src/program_store.sv */
// Program store holding the kernel, host written with a registered fetch port
`default_nettype none
`timescale 1ns/10ps

module program_store (
    input  wire                                clk,
    input  wire                                prog_we,
    input  wire  [gpu_isa_pkg::pc_w-1:0]       prog_addr,
    input  wire  [gpu_isa_pkg::instr_w-1:0]    prog_instr,
    input  wire  [gpu_isa_pkg::pc_w-1:0]       fetch_addr,
    output logic [gpu_isa_pkg::instr_w-1:0]    fetch_instr
);

    localparam int depth = 1 << gpu_isa_pkg::pc_w;

    logic [gpu_isa_pkg::instr_w-1:0] mem [depth];

    // One host write per cycle
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_instr;
        end
    end

    // Word is ready one cycle after the address
    always_ff @(posedge clk) begin
        fetch_instr <= mem[fetch_addr];
    end

endmodule

`default_nettype wire

/* src/thread_lane.sv */
// Thread lane with its own register file, ALU and load writeback
`default_nettype none
`timescale 1ns/10ps

module thread_lane #(
    parameter int lane_index = 0
) (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire  gpu_isa_pkg::decoded_instr_t    instr,
    input  wire                                  exec,
    input  wire                                  active,
    input  wire                                  load_valid,
    input  wire  [gpu_isa_pkg::data_w-1:0]       load_data,
    input  wire  [gpu_isa_pkg::tc_w-1:0]         thread_count,
    output gpu_bus_pkg::lane_mem_req_t           mem_req
);

    localparam int data_w = gpu_isa_pkg::data_w;
    localparam int reg_addr_w = gpu_isa_pkg::reg_addr_w;

    // r14 and r15 are not stored
    logic [data_w-1:0] regs [gpu_isa_pkg::num_regs-2];

    logic [data_w-1:0] rs_val;
    logic [data_w-1:0] rt_val;
    logic [data_w-1:0] alu_result;
    logic              alu_wr;
    logic              rd_writable;

    function automatic logic [data_w-1:0] read_reg(input logic [reg_addr_w-1:0] idx);
        if (idx == reg_addr_w'(gpu_isa_pkg::reg_lane)) begin
            return data_w'(lane_index);
        end
        if (idx == reg_addr_w'(gpu_isa_pkg::reg_tcount)) begin
            return data_w'(thread_count);
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs_val = read_reg(instr.rs);
        rt_val = read_reg(instr.rt);
    end

    assign mem_req.addr = rs_val;
    assign mem_req.wdata = rt_val;
    assign rd_writable = instr.rd < reg_addr_w'(gpu_isa_pkg::reg_tcount);

    always_comb begin
        alu_wr = 1'b1;
        unique case (instr.op)
            gpu_isa_pkg::ADD:   alu_result = rs_val + rt_val;
            gpu_isa_pkg::SUB:   alu_result = rs_val - rt_val;
            // Low byte of the product
            gpu_isa_pkg::MUL:   alu_result = data_w'(rs_val * rt_val);
            gpu_isa_pkg::AND:   alu_result = rs_val & rt_val;
            gpu_isa_pkg::CONST: alu_result = instr.imm;
            default: begin
                alu_result = '0;
                alu_wr = 1'b0;
            end
        endcase
    end

    // ALU result at the end of EXECUTE, load data when the arbiter returns it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < gpu_isa_pkg::num_regs - 2; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_writable) begin
            if (exec && active && alu_wr) begin
                regs[instr.rd] <= alu_result;
            end else if (load_valid) begin
                regs[instr.rd] <= load_data;
            end
        end
    end

endmodule

`default_nettype wire

/* src/data_port_arbiter.sv */
// Data port arbiter running one Wishbone classic cycle per active lane in lane order
`default_nettype none
`timescale 1ns/10ps

module data_port_arbiter (
    input  wire                                                         clk,
    input  wire                                                         rst_n,
    input  wire                                                         mem_start,
    input  wire                                                         mem_is_store,
    input  wire  [gpu_isa_pkg::num_lanes-1:0]                           active_mask,
    input  wire  gpu_bus_pkg::lane_mem_req_t [gpu_isa_pkg::num_lanes-1:0] lane_req,
    input  wire  gpu_bus_pkg::wb_rsp_t                                  wb_rsp,
    output gpu_bus_pkg::wb_req_t                                        wb_req,
    output logic [gpu_isa_pkg::num_lanes-1:0]                           load_valid,
    output logic [gpu_isa_pkg::data_w-1:0]                              load_data,
    output logic                                                        mem_done
);

    localparam int num_lanes = gpu_isa_pkg::num_lanes;
    localparam int lane_idx_w = gpu_isa_pkg::lane_idx_w;

    logic [num_lanes-1:0]          pending_q;
    logic                          store_q;
    logic                          cyc_q;
    logic [lane_idx_w-1:0]         cur_q;
    logic [gpu_bus_pkg::adr_w-1:0] adr_q;
    logic [gpu_bus_pkg::dat_w-1:0] dat_q;
    logic [lane_idx_w-1:0]         next_lane;
    logic                          launch;
    logic                          finish;

    // Lowest pending lane is served first
    always_comb begin
        next_lane = '0;
        for (int i = num_lanes - 1; i >= 0; i--) begin
            if (pending_q[i]) begin
                next_lane = lane_idx_w'(i);
            end
        end
    end

    // A new cycle only starts after cyc has been low for a clock
    assign launch = !cyc_q && (pending_q != '0);
    assign finish = cyc_q && wb_rsp.ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending_q <= '0;
            store_q <= 1'b0;
            cyc_q <= 1'b0;
            load_valid <= '0;
            mem_done <= 1'b0;
        end else begin
            load_valid <= '0;
            mem_done <= 1'b0;
            if (mem_start) begin
                pending_q <= active_mask;
                store_q <= mem_is_store;
                mem_done <= (active_mask == '0);
            end else if (launch) begin
                cyc_q <= 1'b1;
            end else if (finish) begin
                cyc_q <= 1'b0;
                pending_q[cur_q] <= 1'b0;
                load_valid[cur_q] <= !store_q;
                mem_done <= (pending_q & ~(num_lanes'(1) << cur_q)) == '0;
            end
        end
    end

    // Address and data are captured once and held until ack
    always_ff @(posedge clk) begin
        if (launch) begin
            cur_q <= next_lane;
            adr_q <= lane_req[next_lane].addr;
            dat_q <= lane_req[next_lane].wdata;
        end
        if (finish) begin
            load_data <= wb_rsp.dat;
        end
    end

    always_comb begin
        wb_req.cyc = cyc_q;
        wb_req.stb = cyc_q;
        wb_req.we = store_q;
        wb_req.adr = adr_q;
        wb_req.dat = dat_q;
    end

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.stb |-> wb_req.cyc);

    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.stb && !wb_rsp.ack |=> $stable({wb_req.we, wb_req.adr, wb_req.dat}));

endmodule

`default_nettype wire

/* src/core_scheduler.sv */
// Core scheduler FSM stepping the kernel through fetch, decode, execute and memory
`default_nettype none
`timescale 1ns/10ps

module core_scheduler (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  start,
    input  wire  [gpu_isa_pkg::tc_w-1:0]         thread_count,
    input  wire  [gpu_isa_pkg::instr_w-1:0]      fetch_instr,
    input  wire                                  mem_done,
    output logic [gpu_isa_pkg::pc_w-1:0]         fetch_addr,
    output gpu_isa_pkg::decoded_instr_t          instr,
    output logic                                 exec,
    output logic [gpu_isa_pkg::num_lanes-1:0]    active_mask,
    output logic [gpu_isa_pkg::tc_w-1:0]         active_count,
    output logic                                 mem_start,
    output logic                                 mem_is_store,
    output logic                                 done
);

    gpu_isa_pkg::sched_state_e         state_q;
    logic [gpu_isa_pkg::pc_w-1:0]      pc_q;
    logic [gpu_isa_pkg::tc_w-1:0]      count_q;
    logic                              mem_op;

    function automatic gpu_isa_pkg::decoded_instr_t decode(
        input logic [gpu_isa_pkg::instr_w-1:0] word
    );
        gpu_isa_pkg::decoded_instr_t d;
        // Unused opcodes fall back to NOP
        if (word[15:12] > gpu_isa_pkg::RET) begin
            d.op = gpu_isa_pkg::NOP;
        end else begin
            d.op = gpu_isa_pkg::opcode_e'(word[15:12]);
        end
        d.rd = word[11:8];
        d.rs = word[7:4];
        d.rt = word[3:0];
        d.imm = word[7:0];
        return d;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= gpu_isa_pkg::IDLE;
            pc_q <= '0;
            count_q <= gpu_isa_pkg::tc_w'(gpu_isa_pkg::num_lanes);
        end else begin
            unique case (state_q)
                gpu_isa_pkg::IDLE, gpu_isa_pkg::DONE: begin
                    if (start) begin
                        state_q <= gpu_isa_pkg::FETCH;
                        pc_q <= '0;
                        count_q <= thread_count;
                    end
                end
                gpu_isa_pkg::FETCH: begin
                    state_q <= gpu_isa_pkg::DECODE;
                end
                gpu_isa_pkg::DECODE: begin
                    state_q <= gpu_isa_pkg::EXECUTE;
                    pc_q <= pc_q + 1'b1;
                end
                gpu_isa_pkg::EXECUTE: begin
                    if (instr.op == gpu_isa_pkg::RET) begin
                        state_q <= gpu_isa_pkg::DONE;
                    end else if (mem_op) begin
                        state_q <= gpu_isa_pkg::MEMORY;
                    end else begin
                        state_q <= gpu_isa_pkg::FETCH;
                    end
                end
                gpu_isa_pkg::MEMORY: begin
                    if (mem_done) begin
                        state_q <= gpu_isa_pkg::FETCH;
                    end
                end
                default: begin
                    state_q <= gpu_isa_pkg::IDLE;
                end
            endcase
        end
    end

    // Fetched word is valid in DECODE and held through MEMORY
    always_ff @(posedge clk) begin
        if (state_q == gpu_isa_pkg::DECODE) begin
            instr <= decode(fetch_instr);
        end
    end

    assign mem_op = (instr.op == gpu_isa_pkg::LDR) || (instr.op == gpu_isa_pkg::STR);
    assign fetch_addr = pc_q;
    assign exec = (state_q == gpu_isa_pkg::EXECUTE);
    assign mem_start = exec && mem_op;
    assign mem_is_store = (instr.op == gpu_isa_pkg::STR);
    assign active_count = count_q;
    assign done = (state_q == gpu_isa_pkg::DONE);

    // Lanes 0 to count-1 take part
    always_comb begin
        for (int i = 0; i < gpu_isa_pkg::num_lanes; i++) begin
            active_mask[i] = i < count_q;
        end
    end

    a_mem_start: assert property (@(posedge clk) disable iff (!rst_n)
        mem_start |-> state_q == gpu_isa_pkg::EXECUTE && mem_op
            ##1 state_q == gpu_isa_pkg::MEMORY);

endmodule

`default_nettype wire

/* src/gpu_top.sv */
// Compute unit top joining scheduler, program store, four lanes and the data port
`default_nettype none
`timescale 1ns/10ps

module gpu_top (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  start,
    input  wire  [gpu_isa_pkg::tc_w-1:0]         thread_count,
    input  wire                                  prog_we,
    input  wire  [gpu_isa_pkg::pc_w-1:0]         prog_addr,
    input  wire  [gpu_isa_pkg::instr_w-1:0]      prog_instr,
    input  wire  gpu_bus_pkg::wb_rsp_t           wb_rsp,
    output logic                                 done,
    output gpu_bus_pkg::wb_req_t                 wb_req
);

    logic [gpu_isa_pkg::pc_w-1:0]      fetch_addr;
    logic [gpu_isa_pkg::instr_w-1:0]   fetch_instr;
    gpu_isa_pkg::decoded_instr_t       instr;
    logic                              exec;
    logic [gpu_isa_pkg::num_lanes-1:0] active_mask;
    logic [gpu_isa_pkg::tc_w-1:0]      active_count;
    logic                              mem_start;
    logic                              mem_is_store;
    logic                              mem_done;
    logic [gpu_isa_pkg::num_lanes-1:0] load_valid;
    logic [gpu_isa_pkg::data_w-1:0]    load_data;

    gpu_bus_pkg::lane_mem_req_t [gpu_isa_pkg::num_lanes-1:0] lane_req;

    core_scheduler scheduler_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .thread_count (thread_count),
        .fetch_instr  (fetch_instr),
        .mem_done     (mem_done),
        .fetch_addr   (fetch_addr),
        .instr        (instr),
        .exec         (exec),
        .active_mask  (active_mask),
        .active_count (active_count),
        .mem_start    (mem_start),
        .mem_is_store (mem_is_store),
        .done         (done)
    );

    program_store program_store_inst (
        .clk         (clk),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_instr  (prog_instr),
        .fetch_addr  (fetch_addr),
        .fetch_instr (fetch_instr)
    );

    for (genvar i = 0; i < gpu_isa_pkg::num_lanes; i++) begin : g_lane
        thread_lane #(
            .lane_index (i)
        ) lane_inst (
            .clk          (clk),
            .rst_n        (rst_n),
            .instr        (instr),
            .exec         (exec),
            .active       (active_mask[i]),
            .load_valid   (load_valid[i]),
            .load_data    (load_data),
            .thread_count (active_count),
            .mem_req      (lane_req[i])
        );
    end

    data_port_arbiter arbiter_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_start    (mem_start),
        .mem_is_store (mem_is_store),
        .active_mask  (active_mask),
        .lane_req     (lane_req),
        .wb_rsp       (wb_rsp),
        .wb_req       (wb_req),
        .load_valid   (load_valid),
        .load_data    (load_data),
        .mem_done     (mem_done)
    );

endmodule

`default_nettype wire

/* dv/gpu_checker.sv */
// Checker with a lane and memory model that predicts every Wishbone cycle and the done event
`default_nettype none
`timescale 1ns/10ps

module gpu_checker (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              start,
    input  wire  [gpu_isa_pkg::tc_w-1:0]     thread_count,
    input  wire                              prog_we,
    input  wire  [gpu_isa_pkg::pc_w-1:0]     prog_addr,
    input  wire  [gpu_isa_pkg::instr_w-1:0]  prog_instr,
    input  wire                              done,
    input  wire  gpu_bus_pkg::wb_req_t       wb_req,
    input  wire  gpu_bus_pkg::wb_rsp_t       wb_rsp,
    output int                               error_count,
    output int                               check_count
);

    typedef struct packed {
        logic       we;
        logic [7:0] adr;
        logic [7:0] dat;
        logic [1:0] lane;
        logic [3:0] rd;
    } bus_cycle_t;

    logic [15:0] prog [256];
    logic [7:0]  regs [4][14];
    logic [7:0]  mem_model [256];
    bit          mem_known [256];
    bus_cycle_t  exp_q [$];
    logic [7:0]  pc;
    logic [2:0]  count;
    bit          running;
    bit          expect_done;
    bit          started;
    bit          done_q;
    bit          start_q;
    bit          hold_valid;
    logic [16:0] held;

    function automatic logic [7:0] reg_value(input int lane, input logic [3:0] idx);
        if (idx == 4'd15) begin
            return 8'(lane);
        end
        if (idx == 4'd14) begin
            return 8'(count);
        end
        return regs[lane][idx];
    endfunction

    task automatic compare_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("%s", msg);
    endtask

    // Step the kernel up to the next memory op or RET
    task automatic advance();
        logic [15:0] word;
        logic [3:0]  op;
        logic [3:0]  rd;
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  res;
        bus_cycle_t  entry;
        bit          stop;
        int          steps;
        stop = 1'b0;
        steps = 0;
        while (!stop && steps < 256) begin
            word = prog[pc];
            pc = pc + 1'b1;
            steps++;
            op = word[15:12];
            rd = word[11:8];
            for (int l = 0; l < count; l++) begin
                a = reg_value(l, word[7:4]);
                b = reg_value(l, word[3:0]);
                case (op)
                    gpu_isa_pkg::ADD:   res = a + b;
                    gpu_isa_pkg::SUB:   res = a - b;
                    // Low byte of the product
                    gpu_isa_pkg::MUL:   res = a * b;
                    gpu_isa_pkg::AND:   res = a & b;
                    gpu_isa_pkg::CONST: res = word[7:0];
                    default:            res = '0;
                endcase
                if (op >= gpu_isa_pkg::ADD && op <= gpu_isa_pkg::CONST && rd < 4'd14) begin
                    regs[l][rd] = res;
                end
                if (op == gpu_isa_pkg::LDR || op == gpu_isa_pkg::STR) begin
                    entry.we = (op == gpu_isa_pkg::STR);
                    entry.adr = a;
                    entry.dat = b;
                    entry.lane = 2'(l);
                    entry.rd = rd;
                    exp_q.push_back(entry);
                end
            end
            if (op == gpu_isa_pkg::LDR || op == gpu_isa_pkg::STR) begin
                stop = 1'b1;
            end
            if (op == gpu_isa_pkg::RET) begin
                expect_done = 1'b1;
                stop = 1'b1;
            end
        end
    endtask

    task automatic take_cycle();
        bus_cycle_t e;
        if (exp_q.size() == 0) begin
            report_error($sformatf("Unexpected Wishbone cycle at address 0x%02h", wb_req.adr));
            return;
        end
        e = exp_q.pop_front();
        compare_value("wb_req.we", 8'(wb_req.we), 8'(e.we));
        compare_value("wb_req.adr", wb_req.adr, e.adr);
        if (e.we) begin
            compare_value("wb_req.dat", wb_req.dat, e.dat);
            mem_model[e.adr] = e.dat;
        end else begin
            if (mem_known[e.adr]) begin
                compare_value("wb_rsp.dat", wb_rsp.dat, mem_model[e.adr]);
            end
            mem_model[e.adr] = wb_rsp.dat;
            if (e.rd < 4'd14) begin
                regs[e.lane][e.rd] = wb_rsp.dat;
            end
        end
        mem_known[e.adr] = 1'b1;
        if (exp_q.size() == 0 && running && !expect_done) begin
            advance();
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int l = 0; l < 4; l++) begin
                for (int r = 0; r < 14; r++) begin
                    regs[l][r] = '0;
                end
            end
            exp_q.delete();
            running = 1'b0;
            expect_done = 1'b0;
            started = 1'b0;
            done_q = 1'b0;
            start_q = 1'b0;
            hold_valid = 1'b0;
            error_count = 0;
            check_count = 0;
        end else begin
            if (prog_we === 1'b1) begin
                prog[prog_addr] = prog_instr;
            end
            // Nothing moves before the first kernel
            if (!started) begin
                compare_value("wb_req.cyc", 8'(wb_req.cyc), 8'h00);
                compare_value("wb_req.stb", 8'(wb_req.stb), 8'h00);
                compare_value("done", 8'(done), 8'h00);
            end
            // A stalled request keeps its address and data
            if (hold_valid && wb_req.cyc === 1'b1) begin
                compare_value("wb_req.we", 8'(wb_req.we), 8'(held[16]));
                compare_value("wb_req.adr", wb_req.adr, held[15:8]);
                compare_value("wb_req.dat", wb_req.dat, held[7:0]);
            end
            hold_valid = (wb_req.cyc === 1'b1) && (wb_req.stb === 1'b1) && (wb_rsp.ack !== 1'b1);
            held = {wb_req.we, wb_req.adr, wb_req.dat};
            if (wb_req.cyc === 1'b1 && wb_req.stb === 1'b1 && wb_rsp.ack === 1'b1) begin
                take_cycle();
            end
            if (done === 1'b1 && !done_q) begin
                if (!expect_done) begin
                    report_error($sformatf("done rose before RET with %0d bus cycles missing",
                        exp_q.size()));
                end
                running = 1'b0;
                expect_done = 1'b0;
            end
            if (done_q && done !== 1'b1 && !start_q) begin
                report_error("done dropped without a new start");
            end
            // An accepted start clears done on the next edge
            if (start_q && done !== 1'b0) begin
                report_error("done did not clear after a new start");
            end
            if (start === 1'b1 && !running) begin
                started = 1'b1;
                running = 1'b1;
                expect_done = 1'b0;
                pc = '0;
                count = thread_count;
                exp_q.delete();
                advance();
            end
            done_q = (done === 1'b1);
            start_q = (start === 1'b1);
        end
    end

endmodule

`default_nettype wire

/* dv/gpu_tb.sv */
// Testbench for the compute unit with random kernels and a Wishbone memory with wait states
`default_nettype none
`timescale 1ns/10ps

module gpu_tb;

    localparam int period_ns = 20;
    localparam int num_kernels = 20;
    localparam int max_body = 20;
    // Three cycles per instruction plus up to six per lane on a memory op
    localparam longint watchdog_ns = longint'(num_kernels) * (max_body + 1)
        * (3 + gpu_isa_pkg::num_lanes * 6) * period_ns + 50000;

    logic                            clk = 1'b0;
    logic                            rst_n;
    logic                            start;
    logic [gpu_isa_pkg::tc_w-1:0]    thread_count;
    logic                            prog_we;
    logic [gpu_isa_pkg::pc_w-1:0]    prog_addr;
    logic [gpu_isa_pkg::instr_w-1:0] prog_instr;
    logic                            done;
    gpu_bus_pkg::wb_req_t            wb_req;
    gpu_bus_pkg::wb_rsp_t            wb_rsp;
    int                              error_count;
    int                              check_count;

    // Data memory behind the Wishbone port
    logic [7:0] mem [256];

    always #(period_ns / 2) clk = ~clk;

    gpu_top gpu_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .thread_count (thread_count),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_instr   (prog_instr),
        .wb_rsp       (wb_rsp),
        .done         (done),
        .wb_req       (wb_req)
    );

    gpu_checker checker_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .thread_count (thread_count),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_instr   (prog_instr),
        .done         (done),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .error_count  (error_count),
        .check_count  (check_count)
    );

    // Source operands favor the thread count and lane index registers
    function automatic logic [3:0] pick_source();
        int r;
        r = $urandom_range(0, 5);
        if (r == 0) begin
            return 4'd14;
        end
        if (r == 1) begin
            return 4'd15;
        end
        return 4'($urandom_range(0, 15));
    endfunction

    function automatic logic [15:0] random_instr();
        logic [3:0] op;
        logic [3:0] rd;
        int         sel;
        sel = $urandom_range(0, 9);
        rd = 4'($urandom_range(0, 15));
        case (sel)
            0: op = gpu_isa_pkg::ADD;
            1: op = gpu_isa_pkg::SUB;
            2: op = gpu_isa_pkg::MUL;
            3: op = gpu_isa_pkg::AND;
            4: op = gpu_isa_pkg::CONST;
            5: op = gpu_isa_pkg::LDR;
            6, 7: op = gpu_isa_pkg::STR;
            8: op = gpu_isa_pkg::NOP;
            // Unused codes behave as NOP
            default: op = 4'($urandom_range(9, 15));
        endcase
        if (op == gpu_isa_pkg::CONST) begin
            return {op, rd, 8'($urandom_range(0, 255))};
        end
        return {op, rd, pick_source(), pick_source()};
    endfunction

    task automatic load_program(input int len);
        for (int i = 0; i <= len; i++) begin
            @(posedge clk);
            #2;
            prog_we = 1'b1;
            prog_addr = 8'(i);
            prog_instr = (i == len) ? {4'(gpu_isa_pkg::RET), 12'h000} : random_instr();
        end
        @(posedge clk);
        #2;
        prog_we = 1'b0;
    endtask

    task automatic run_kernel();
        @(posedge clk);
        #2;
        thread_count = 3'($urandom_range(1, 4));
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        while (done !== 1'b1) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Slave side answers each cycle after zero to three wait states
    always begin : memory_responder
        int waits;
        @(posedge clk);
        #2;
        if (rst_n === 1'b1 && wb_req.cyc === 1'b1 && wb_req.stb === 1'b1) begin
            waits = $urandom_range(0, 3);
            repeat (waits) begin
                @(posedge clk);
                #2;
            end
            wb_rsp.ack = 1'b1;
            if (wb_req.we) begin
                mem[wb_req.adr] = wb_req.dat;
            end else begin
                wb_rsp.dat = mem[wb_req.adr];
            end
            @(posedge clk);
            #2;
            wb_rsp.ack = 1'b0;
        end
    end

    initial begin
        int len;
        void'($urandom(32'hc426_8a75));
        rst_n = 1'b0;
        start = 1'b0;
        thread_count = 3'd4;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_instr = '0;
        wb_rsp = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'($urandom_range(0, 255));
        end
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // Quiet period before the first start
        repeat (5) @(posedge clk);
        for (int k = 0; k < num_kernels; k++) begin
            len = $urandom_range(6, max_body);
            load_program(len);
            run_kernel();
            repeat ($urandom_range(0, 4)) @(posedge clk);
        end
        repeat (4) @(posedge clk);
        #2;
        $display("Kernels: %0d, checks: %0d, errors: %0d", num_kernels, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
src/gpu_isa_pkg.sv
src/gpu_bus_pkg.sv
src/program_store.sv
src/thread_lane.sv
src/data_port_arbiter.sv
src/core_scheduler.sv
src/gpu_top.sv
dv/gpu_checker.sv
dv/gpu_tb.sv

/* Bender.yml */
package:
  name: gpu_simt

sources:
  - src/gpu_isa_pkg.sv
  - src/gpu_bus_pkg.sv
  - src/program_store.sv
  - src/thread_lane.sv
  - src/data_port_arbiter.sv
  - src/core_scheduler.sv
  - src/gpu_top.sv
  - target: test
    files:
      - dv/gpu_checker.sv
      - dv/gpu_tb.sv
